// ==== all.f ====
+incdir+source
source/capture_pkg.sv
source/adc_front_end.sv
source/capture_fsm.sv
source/capture_counter.sv
source/sample_buffer.sv
source/capture_regs.sv
source/adc_capture_top.sv
tests/capture_checker.sv
tests/capture_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the capture testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module capture_tb -f all.f
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/Vcapture_tb)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if printf '%s\n' "$sim_out" | grep -q "^TESTBENCH PASSED$"; then
   exit 0
fi
echo "pass message not found in simulation output"
exit 1

// ==== source/adc_capture_top.sv ====
`timescale 1ns/100ps
`include "capture_macros.svh"

module adc_capture_top (
   input  logic                 ADC_clk_sample,
   input  logic                 reset,
   input  logic                 wb_cyc_i,
   input  logic                 wb_stb_i,
   input  logic                 wb_we_i,
   input  logic [`WB_AW-1:0]    wb_adr_i,
   input  logic [`WB_DW-1:0]    wb_dat_i,
   output logic [`WB_DW-1:0]    wb_dat_o,
   output logic                 wb_ack_o,
   input  logic [`SAMPLE_W-1:0] adc_data_i,
   input  logic                 trigger_i,
   output logic                 trigger_adc_o,
   output logic                 armed_o,
   output logic                 capture_active_o
);

   capture_pkg::data_source_e data_source;

   logic                 arm;
   logic                 trig_now;
   logic                 trigger_mode;
   logic                 trigger_wait;
   logic [`SAMPLE_W-1:0] adc_level;
   logic [`WB_DW-1:0]    offset;
   logic [`BUF_AW:0]     samples;
   logic                 count_zero;
   logic                 load_offset;
   logic                 load_samples;
   logic                 count_en;
   logic                 wr_en;
   logic                 wr_restart;
   logic                 level_arm;
   logic                 done;
   logic [`SAMPLE_W-1:0] sample;
   logic [`SAMPLE_W-1:0] rd_data;
   logic [`BUF_AW:0]     stored;
   logic                 rd_advance;
   logic                 rd_restart;

   adc_front_end u_front_end (
      .ADC_clk_sample (ADC_clk_sample),
      .reset          (reset),
      .adc_data_i     (adc_data_i),
      .data_source_i  (data_source),
      .adc_level_i    (adc_level),
      .level_arm_i    (level_arm),
      .sample_o       (sample),
      .trigger_adc_o  (trigger_adc_o)
   );

   capture_counter u_counter (
      .ADC_clk_sample (ADC_clk_sample),
      .reset          (reset),
      .load_offset_i  (load_offset),
      .load_samples_i (load_samples),
      .count_en_i     (count_en),
      .offset_i       (offset),
      .samples_i      (samples),
      .count_zero_o   (count_zero)
   );

   capture_fsm u_fsm (
      .ADC_clk_sample   (ADC_clk_sample),
      .reset            (reset),
      .arm_i            (arm),
      .trig_now_i       (trig_now),
      .trigger_mode_i   (trigger_mode),
      .trigger_wait_i   (trigger_wait),
      .trigger_i        (trigger_i),
      .count_zero_i     (count_zero),
      .load_offset_o    (load_offset),
      .load_samples_o   (load_samples),
      .count_en_o       (count_en),
      .wr_en_o          (wr_en),
      .wr_restart_o     (wr_restart),
      .level_arm_o      (level_arm),
      .armed_o          (armed_o),
      .capture_active_o (capture_active_o),
      .done_o           (done)
   );

   sample_buffer u_buffer (
      .ADC_clk_sample (ADC_clk_sample),
      .reset          (reset),
      .wr_en_i        (wr_en),
      .wr_restart_i   (wr_restart),
      .wr_data_i      (sample),
      .rd_advance_i   (rd_advance),
      .rd_restart_i   (rd_restart),
      .rd_data_o      (rd_data),
      .stored_o       (stored)
   );

   capture_regs u_regs (
      .ADC_clk_sample (ADC_clk_sample),
      .reset          (reset),
      .wb_cyc_i       (wb_cyc_i),
      .wb_stb_i       (wb_stb_i),
      .wb_we_i        (wb_we_i),
      .wb_adr_i       (wb_adr_i),
      .wb_dat_i       (wb_dat_i),
      .wb_dat_o       (wb_dat_o),
      .wb_ack_o       (wb_ack_o),
      .armed_i        (armed_o),
      .active_i       (capture_active_o),
      .done_i         (done),
      .trigger_i      (trigger_i),
      .rd_data_i      (rd_data),
      .stored_i       (stored),
      .arm_o          (arm),
      .trig_now_o     (trig_now),
      .trigger_mode_o (trigger_mode),
      .trigger_wait_o (trigger_wait),
      .data_source_o  (data_source),
      .adc_level_o    (adc_level),
      .offset_o       (offset),
      .samples_o      (samples),
      .rd_advance_o   (rd_advance),
      .rd_restart_o   (rd_restart)
   );

endmodule

// ==== source/adc_front_end.sv ====
`timescale 1ns/100ps
`include "capture_macros.svh"

module adc_front_end (
   input  logic                      ADC_clk_sample,
   input  logic                      reset,
   input  logic [`SAMPLE_W-1:0]      adc_data_i,
   input  capture_pkg::data_source_e data_source_i,
   input  logic [`SAMPLE_W-1:0]      adc_level_i,
   input  logic                      level_arm_i,
   output logic [`SAMPLE_W-1:0]      sample_o,
   output logic                      trigger_adc_o
);
   import capture_pkg::*;

   logic [`SAMPLE_W-1:0] pattern_q;
   logic [`SAMPLE_W-1:0] stage1_q;
   logic [`SAMPLE_W-1:0] stage2_q;
   logic                 level_allowed_q;   // one pulse per arming
   logic                 past_level;

   // free running test pattern
   always_ff @(posedge ADC_clk_sample) begin
      if (reset)
         pattern_q <= '0;
      else
         pattern_q <= pattern_q + `SAMPLE_W'(1);
   end

   // two register stages between pins and buffer
   always_ff @(posedge ADC_clk_sample) begin
      stage1_q <= (data_source_i == src_adc) ? adc_data_i : pattern_q;
      stage2_q <= stage1_q;
   end

   assign sample_o = stage2_q;

   // top bit of the level picks the direction
   assign past_level = adc_level_i[`SAMPLE_W-1] ? (stage2_q > adc_level_i)
                                                : (stage2_q < adc_level_i);

   always_ff @(posedge ADC_clk_sample) begin
      if (reset) begin
         level_allowed_q <= 1'b0;
         trigger_adc_o   <= 1'b0;
      end else begin
         trigger_adc_o <= level_allowed_q && past_level;
         // firing wins so the pulse can never last two cycles
         if (level_allowed_q && past_level)
            level_allowed_q <= 1'b0;
         else if (level_arm_i)
            level_allowed_q <= 1'b1;
      end
   end

endmodule

// ==== source/capture_counter.sv ====
`timescale 1ns/100ps
`include "capture_macros.svh"

module capture_counter (
   input  logic              ADC_clk_sample,
   input  logic              reset,
   input  logic              load_offset_i,
   input  logic              load_samples_i,
   input  logic              count_en_i,
   input  logic [`WB_DW-1:0] offset_i,
   input  logic [`BUF_AW:0]  samples_i,
   output logic              count_zero_o
);

   logic [`WB_DW-1:0] count_q;
   logic [`WB_DW-1:0] samples_ext;

   assign samples_ext = `WB_DW'(samples_i);

   always_ff @(posedge ADC_clk_sample) begin
      if (reset) begin
         count_q <= '0;
      end else if (load_samples_i) begin
         // zero seen on the last capture cycle
         count_q <= (samples_ext == '0) ? '0 : samples_ext - `WB_DW'(1);
      end else if (load_offset_i) begin
         count_q <= offset_i;
      end else if (count_en_i && !count_zero_o) begin
         count_q <= count_q - `WB_DW'(1);
      end
   end

   assign count_zero_o = (count_q == '0);

endmodule

// ==== source/capture_fsm.sv ====
`timescale 1ns/100ps

module capture_fsm (
   input  logic ADC_clk_sample,
   input  logic reset,
   input  logic arm_i,
   input  logic trig_now_i,
   input  logic trigger_mode_i,    // 1 = active high
   input  logic trigger_wait_i,
   input  logic trigger_i,
   input  logic count_zero_i,
   output logic load_offset_o,
   output logic load_samples_o,
   output logic count_en_o,
   output logic wr_en_o,
   output logic wr_restart_o,
   output logic level_arm_o,
   output logic armed_o,
   output logic capture_active_o,
   output logic done_o
);
   import capture_pkg::*;

   capture_state_e state_q;
   capture_state_e state_d;
   logic           trig_q;
   logic           trig_active;
   logic           fire;

   assign trig_active = trigger_mode_i ? trig_q : ~trig_q;
   assign fire        = trig_active || trig_now_i;

   always_comb begin
      state_d        = state_q;
      load_offset_o  = 1'b0;
      load_samples_o = 1'b0;
      count_en_o     = 1'b0;
      wr_restart_o   = 1'b0;
      case (state_q)
         st_idle, st_done: begin
            load_offset_o = 1'b1;
            // no rearm while the last sample is still going in
            if (arm_i && !wr_en_o) begin
               wr_restart_o = 1'b1;
               state_d      = trigger_wait_i ? st_wait_inactive : st_armed;
            end
         end
         st_wait_inactive: begin
            load_offset_o = 1'b1;
            if (!trig_active)
               state_d = st_armed;
         end
         st_armed: begin
            if (!fire) begin
               load_offset_o = 1'b1;   // counter tracks the offset register
            end else if (count_zero_i) begin
               load_samples_o = 1'b1;  // zero offset, straight to capture
               state_d        = st_capture;
            end else begin
               count_en_o = 1'b1;
               state_d    = st_offset;
            end
         end
         st_offset: begin
            if (count_zero_i) begin
               load_samples_o = 1'b1;
               state_d        = st_capture;
            end else begin
               count_en_o = 1'b1;
            end
         end
         st_capture: begin
            if (count_zero_i)
               state_d = st_done;
            else
               count_en_o = 1'b1;
         end
         default: state_d = st_idle;
      endcase
   end

   always_ff @(posedge ADC_clk_sample) begin
      if (reset) begin
         state_q     <= st_idle;
         trig_q      <= 1'b0;
         wr_en_o     <= 1'b0;
         level_arm_o <= 1'b0;
      end else begin
         state_q     <= state_d;
         trig_q      <= trigger_i;
         wr_en_o     <= (state_q == st_capture);  // lines up with pipeline depth
         level_arm_o <= (state_d == st_armed) && (state_q != st_armed);
      end
   end

   assign armed_o          = (state_q == st_armed) || (state_q == st_wait_inactive);
   assign capture_active_o = (state_q == st_offset) || (state_q == st_capture) || wr_en_o;
   assign done_o           = (state_q == st_done) && !wr_en_o;

endmodule

// ==== source/capture_macros.svh ====
`ifndef CAPTURE_MACROS_SVH
`define CAPTURE_MACROS_SVH

// one ADC sample
`define SAMPLE_W 12

// sample buffer address width, 512 entries
`define BUF_AW 9

// wishbone widths
`define WB_AW 4
`define WB_DW 32

`endif

// ==== source/capture_pkg.sv ====
`include "capture_macros.svh"

package capture_pkg;

   typedef enum logic [2:0] {
      st_idle,
      st_wait_inactive,   // trigger must drop before arming
      st_armed,
      st_offset,
      st_capture,
      st_done
   } capture_state_e;

   // register map, word addresses
   typedef enum logic [`WB_AW-1:0] {
      reg_ctrl         = `WB_AW'(0),
      reg_status       = `WB_AW'(1),
      reg_trig_offset  = `WB_AW'(2),
      reg_sample_count = `WB_AW'(3),
      reg_adc_level    = `WB_AW'(4),
      reg_buf_data     = `WB_AW'(5)
   } reg_addr_e;

   typedef enum logic {src_pattern = 1'b0, src_adc = 1'b1} data_source_e;

endpackage

// ==== source/capture_regs.sv ====
`timescale 1ns/100ps
`include "capture_macros.svh"

module capture_regs (
   input  logic                      ADC_clk_sample,
   input  logic                      reset,
   input  logic                      wb_cyc_i,
   input  logic                      wb_stb_i,
   input  logic                      wb_we_i,
   input  logic [`WB_AW-1:0]         wb_adr_i,
   input  logic [`WB_DW-1:0]         wb_dat_i,
   output logic [`WB_DW-1:0]         wb_dat_o,
   output logic                      wb_ack_o,
   input  logic                      armed_i,
   input  logic                      active_i,
   input  logic                      done_i,
   input  logic                      trigger_i,
   input  logic [`SAMPLE_W-1:0]      rd_data_i,
   input  logic [`BUF_AW:0]          stored_i,
   output logic                      arm_o,
   output logic                      trig_now_o,
   output logic                      trigger_mode_o,
   output logic                      trigger_wait_o,
   output capture_pkg::data_source_e data_source_o,
   output logic [`SAMPLE_W-1:0]      adc_level_o,
   output logic [`WB_DW-1:0]         offset_o,
   output logic [`BUF_AW:0]          samples_o,
   output logic                      rd_advance_o,
   output logic                      rd_restart_o
);
   import capture_pkg::*;

   localparam logic [`BUF_AW:0] DEPTH = (`BUF_AW+1)'(1 << `BUF_AW);

   reg_addr_e         addr;
   logic              req;
   logic              wr_req;
   logic              rd_req;
   logic              wr_ctrl;
   logic [`WB_DW-1:0] rd_mux;

   assign addr    = reg_addr_e'(wb_adr_i);
   assign req     = wb_cyc_i && wb_stb_i && !wb_ack_o;   // one ack per request
   assign wr_req  = req && wb_we_i;
   assign rd_req  = req && !wb_we_i;
   assign wr_ctrl = wr_req && (addr == reg_ctrl);

   always_ff @(posedge ADC_clk_sample) begin
      if (reset) begin
         wb_ack_o       <= 1'b0;
         arm_o          <= 1'b0;
         trig_now_o     <= 1'b0;
         trigger_mode_o <= 1'b1;
         trigger_wait_o <= 1'b0;
         data_source_o  <= src_adc;
         adc_level_o    <= '0;
         offset_o       <= '0;
         samples_o      <= DEPTH;
      end else begin
         wb_ack_o   <= req;
         // pulses land one cycle later so the FSM sees the new mode bits
         arm_o      <= wr_ctrl && wb_dat_i[0];
         trig_now_o <= wr_ctrl && wb_dat_i[3];
         if (wr_req) begin
            case (addr)
               reg_ctrl: begin
                  trigger_mode_o <= wb_dat_i[1];
                  trigger_wait_o <= wb_dat_i[2];
                  data_source_o  <= data_source_e'(wb_dat_i[4]);
               end
               reg_trig_offset: offset_o <= wb_dat_i;
               reg_sample_count: begin
                  if (wb_dat_i > `WB_DW'(DEPTH))
                     samples_o <= DEPTH;   // clamp to buffer size
                  else
                     samples_o <= wb_dat_i[`BUF_AW:0];
               end
               reg_adc_level: adc_level_o <= wb_dat_i[`SAMPLE_W-1:0];
               default: ;   // status and buf_data are read only
            endcase
         end
      end
   end

   always_comb begin
      rd_mux = '0;
      case (addr)
         reg_ctrl: begin
            rd_mux[1] = trigger_mode_o;
            rd_mux[2] = trigger_wait_o;
            rd_mux[4] = data_source_o;
         end
         reg_status: begin
            rd_mux[0] = armed_i;
            rd_mux[1] = active_i;
            rd_mux[2] = done_i;
            rd_mux[3] = trigger_i;
            rd_mux[16 +: `BUF_AW+1] = stored_i;   // samples held
         end
         reg_trig_offset:  rd_mux = offset_o;
         reg_sample_count: rd_mux[`BUF_AW:0] = samples_o;
         reg_adc_level:    rd_mux[`SAMPLE_W-1:0] = adc_level_o;
         reg_buf_data:     rd_mux[`SAMPLE_W-1:0] = rd_data_i;
         default:          rd_mux = '0;
      endcase
   end

   // held while ack is high
   always_ff @(posedge ADC_clk_sample) begin
      if (rd_req)
         wb_dat_o <= rd_mux;
   end

   assign rd_advance_o = rd_req && (addr == reg_buf_data);
   assign rd_restart_o = arm_o;   // readback starts over on each arm

endmodule

// ==== source/sample_buffer.sv ====
`timescale 1ns/100ps
`include "capture_macros.svh"

module sample_buffer (
   input  logic                 ADC_clk_sample,
   input  logic                 reset,
   input  logic                 wr_en_i,
   input  logic                 wr_restart_i,
   input  logic [`SAMPLE_W-1:0] wr_data_i,
   input  logic                 rd_advance_i,
   input  logic                 rd_restart_i,
   output logic [`SAMPLE_W-1:0] rd_data_o,
   output logic [`BUF_AW:0]     stored_o
);

   localparam int DEPTH = 1 << `BUF_AW;

   logic [`SAMPLE_W-1:0] mem [DEPTH];
   logic [`BUF_AW-1:0]   wr_ptr_q;
   logic [`BUF_AW:0]     stored_q;
   logic [`BUF_AW:0]     rd_ptr_q;
   logic [`BUF_AW:0]     rd_ptr_d;
   logic [`SAMPLE_W-1:0] rd_word_q;

   always_ff @(posedge ADC_clk_sample) begin
      if (wr_en_i && !wr_restart_i)
         mem[wr_ptr_q] <= wr_data_i;
   end

   always_ff @(posedge ADC_clk_sample) begin
      if (reset || wr_restart_i) begin
         wr_ptr_q <= '0;
         stored_q <= '0;
      end else if (wr_en_i) begin
         wr_ptr_q <= wr_ptr_q + `BUF_AW'(1);
         if (stored_q != (`BUF_AW+1)'(DEPTH))
            stored_q <= stored_q + (`BUF_AW+1)'(1);
      end
   end

   // pointer stops at the stored count
   always_comb begin
      rd_ptr_d = rd_ptr_q;
      if (rd_restart_i)
         rd_ptr_d = '0;
      else if (rd_advance_i && (rd_ptr_q < stored_q))
         rd_ptr_d = rd_ptr_q + (`BUF_AW+1)'(1);
   end

   always_ff @(posedge ADC_clk_sample) begin
      if (reset)
         rd_ptr_q <= '0;
      else
         rd_ptr_q <= rd_ptr_d;
   end

   always_ff @(posedge ADC_clk_sample) begin
      rd_word_q <= mem[rd_ptr_d[`BUF_AW-1:0]];   // sync read
   end

   assign rd_data_o = (rd_ptr_q < stored_q) ? rd_word_q : '0;
   assign stored_o  = stored_q;

endmodule

// ==== tests/capture_checker.sv ====
`timescale 1ns/100ps

module capture_checker (
   input logic ADC_clk_sample,
   input logic reset,
   input logic cyc_i,
   input logic stb_i,
   input logic ack_i,
   input logic trig_adc_i,
   input logic armed_i,
   input logic active_i
);

   ack_one_cycle: assert property (@(posedge ADC_clk_sample) disable iff (reset)
      ack_i |=> !ack_i)
      else $error("bus ack lasted more than one cycle");

   // ack answers a request seen on the edge before
   ack_needs_stb: assert property (@(posedge ADC_clk_sample) disable iff (reset)
      ack_i |-> $past(cyc_i && stb_i))
      else $error("bus ack without a strobe");

   level_pulse_single: assert property (@(posedge ADC_clk_sample) disable iff (reset)
      trig_adc_i |=> !trig_adc_i)
      else $error("level trigger high for two cycles");

   armed_or_active: assert property (@(posedge ADC_clk_sample) disable iff (reset)
      !(armed_i && active_i))
      else $error("armed and capture active at the same time");

endmodule

// ==== tests/capture_tb.sv ====
`timescale 1ns/100ps
`include "capture_macros.svh"

module capture_tb;
   import capture_pkg::*;

   typedef enum logic {kind_soft, kind_ext} trig_kind_e;

   typedef struct packed {
      data_source_e         src;
      trig_kind_e           kind;
      logic                 mode;      // 1 = active high
      logic                 wait_f;
      logic [`WB_DW-1:0]    offset;
      logic [`WB_DW-1:0]    count;
      logic [`SAMPLE_W-1:0] level;
      int                   delay;     // cycles from armed to trigger
   } row_t;

   localparam int NROWS    = 7;
   localparam int TRIG_LAT = 1;   // trigger_i is registered once ahead of the FSM

   logic                 ADC_clk_sample;
   logic                 reset;
   logic                 wb_cyc_i;
   logic                 wb_stb_i;
   logic                 wb_we_i;
   logic [`WB_AW-1:0]    wb_adr_i;
   logic [`WB_DW-1:0]    wb_dat_i;
   logic [`WB_DW-1:0]    wb_dat_o;
   logic                 wb_ack_o;
   logic [`SAMPLE_W-1:0] adc_data_i = '0;
   logic                 trigger_i;
   logic                 trigger_adc_o;
   logic                 armed_o;
   logic                 capture_active_o;
   int                   pulse_total = 0;
   logic [`SAMPLE_W-1:0] pulse_sample = '0;
   row_t                 rows [NROWS];

   adc_capture_top dut_i (.*);

   bind adc_capture_top capture_checker u_checker (
      .ADC_clk_sample (ADC_clk_sample),
      .reset          (reset),
      .cyc_i          (wb_cyc_i),
      .stb_i          (wb_stb_i),
      .ack_i          (wb_ack_o),
      .trig_adc_i     (trigger_adc_o),
      .armed_i        (armed_o),
      .active_i       (capture_active_o)
   );

   initial begin
      ADC_clk_sample = 1'b0;
      forever #4 ADC_clk_sample = ~ADC_clk_sample;
   end

   // ADC model, one step per clock
   always @(negedge ADC_clk_sample) adc_data_i <= adc_data_i + `SAMPLE_W'(1);

   // the pulsing sample sits two pipeline stages behind the pins
   always @(negedge ADC_clk_sample) begin
      if (trigger_adc_o) begin
         pulse_total  <= pulse_total + 1;
         pulse_sample <= adc_data_i - `SAMPLE_W'(2);
      end
   end

   task automatic stop_on_error(input string why);
      $display("%s", why);
      $display("TESTBENCH FAILED");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_word(input string name, input logic [`WB_DW-1:0] got,
                             input logic [`WB_DW-1:0] exp);
      if (got !== exp)
         stop_on_error($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
   endtask

   task automatic compare_sample(input string name, input logic [`SAMPLE_W-1:0] got,
                                 input logic [`SAMPLE_W-1:0] exp);
      if (got !== exp)
         stop_on_error($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
   endtask

   task automatic expect_state(input string name, input capture_state_e got,
                               input capture_state_e exp);
      if (got !== exp)
         stop_on_error($sformatf("mismatch at %0t: %s got %s expected %s",
                                 $time, name, got.name(), exp.name()));
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp)
         stop_on_error($sformatf("mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
   endtask

   // one classic cycle, called right after a falling edge
   task automatic access(input reg_addr_e addr, input logic we, input logic [`WB_DW-1:0] wdata,
                         output logic [`WB_DW-1:0] rdata);
      int n;
      n = 0;
      wb_cyc_i <= 1'b1;
      wb_stb_i <= 1'b1;
      wb_we_i  <= we;
      wb_adr_i <= addr;
      wb_dat_i <= wdata;
      do begin
         @(negedge ADC_clk_sample);
         n++;
         if (n > 10)
            stop_on_error("timeout: the bus never acknowledged the access");
      end while (!wb_ack_o);
      rdata = wb_dat_o;
      wb_cyc_i <= 1'b0;
      wb_stb_i <= 1'b0;
      wb_we_i  <= 1'b0;
      @(negedge ADC_clk_sample);
   endtask

   task automatic write_reg(input reg_addr_e addr, input logic [`WB_DW-1:0] data);
      logic [`WB_DW-1:0] unused;
      access(addr, 1'b1, data, unused);
   endtask

   task automatic read_reg(input reg_addr_e addr, output logic [`WB_DW-1:0] data);
      access(addr, 1'b0, '0, data);
   endtask

   task automatic wait_armed();
      int n;
      n = 0;
      while (!armed_o) begin
         if (n == 50)
            stop_on_error("timeout: the unit never reported armed");
         @(negedge ADC_clk_sample);
         n++;
      end
   endtask

   task automatic fill_table();
      rows[0] = '{src_pattern, kind_soft, 1'b1, 1'b0, 32'd0, 32'd16, 12'h000, 3};
      rows[1] = '{src_adc, kind_ext, 1'b1, 1'b0, $urandom % 24, 32'd12, 12'hfff, 5};
      rows[2] = '{src_adc, kind_ext, 1'b0, 1'b0, 1 + $urandom % 24, 32'd9, 12'hfff, 7};
      rows[3] = '{src_adc, kind_ext, 1'b1, 1'b1, $urandom % 24, 32'd6, 12'h000, 6};
      rows[4] = '{src_adc, kind_soft, 1'b1, 1'b0, 32'd0, 32'd4,
                  12'h800 | `SAMPLE_W'($urandom % 32'h7ff), 4200};
      rows[5] = '{src_adc, kind_soft, 1'b0, 1'b0, $urandom % 8, 32'd3,
                  12'h001 + `SAMPLE_W'($urandom % 32'h7ff), 4200};
      rows[6] = '{src_pattern, kind_soft, 1'b0, 1'b0, 32'd5, 32'd1, 12'h000, 2};
   endtask

   task automatic run_row(input int idx, input row_t r);
      logic [`WB_DW-1:0]    rd;
      logic [`WB_DW-1:0]    ctrl;
      logic [`SAMPLE_W-1:0] trig_val;
      logic [`SAMPLE_W-1:0] exp_s;
      logic                 passable;
      logic                 past;
      int                   pulses_before;
      int                   n;
      int                   i;
      trig_val = '0;
      exp_s    = '0;
      trigger_i <= r.wait_f ? r.mode : ~r.mode;   // active only for the wait test
      repeat (3) @(negedge ADC_clk_sample);
      write_reg(reg_trig_offset, r.offset);
      write_reg(reg_sample_count, r.count);
      write_reg(reg_adc_level, `WB_DW'(r.level));
      read_reg(reg_trig_offset, rd);
      check_word("trig_offset", rd, r.offset);
      read_reg(reg_sample_count, rd);
      check_word("sample_count", rd, r.count);
      read_reg(reg_adc_level, rd);
      check_word("adc_level", rd, `WB_DW'(r.level));
      pulses_before = pulse_total;
      ctrl = {27'd0, r.src, 1'b0, r.wait_f, r.mode, 1'b0};
      write_reg(reg_ctrl, ctrl | 32'h1);
      wait_armed();
      if (r.wait_f) begin
         repeat (8) begin
            @(negedge ADC_clk_sample);
            expect_state("fsm state with trigger held", dut_i.u_fsm.state_q, st_wait_inactive);
            check_flag("capture_active_o with trigger held", capture_active_o, 1'b0);
         end
         trigger_i <= ~r.mode;
      end
      repeat (r.delay) @(negedge ADC_clk_sample);
      if (r.kind == kind_ext) begin
         trigger_i <= r.mode;
         trig_val = adc_data_i + `SAMPLE_W'(1);   // model steps on this same edge
         // the FSM acts on the edge after the trigger is registered
         @(negedge ADC_clk_sample);
         check_flag("armed_o before the fire edge", armed_o, 1'b1);
         check_flag("capture_active_o before the fire edge", capture_active_o, 1'b0);
         @(negedge ADC_clk_sample);
         check_flag("armed_o after the fire edge", armed_o, 1'b0);
         check_flag("capture_active_o after the fire edge", capture_active_o, 1'b1);
      end else begin
         write_reg(reg_ctrl, ctrl | 32'h8);
      end
      n  = 0;
      rd = '0;
      while (!rd[2]) begin
         if (n == 200)
            stop_on_error($sformatf("timeout: row %0d never reported done", idx));
         read_reg(reg_status, rd);
         n++;
      end
      expect_state("fsm state after capture", dut_i.u_fsm.state_q, st_done);
      check_flag("armed_o after capture", armed_o, 1'b0);
      check_flag("capture_active_o after capture", capture_active_o, 1'b0);
      check_word("status after capture", rd,
                 (r.count << 16) | 32'h4 | (`WB_DW'(trigger_i) << 3));
      for (i = 0; i < int'(r.count); i++) begin
         read_reg(reg_buf_data, rd);
         if (i == 0 && r.kind == kind_soft) begin
            exp_s = rd[`SAMPLE_W-1:0];   // free start, only the step matters
         end else begin
            if (i == 0)
               exp_s = `SAMPLE_W'(32'(trig_val) + r.offset + TRIG_LAT);
            compare_sample($sformatf("row %0d sample %0d", idx, i), rd[`SAMPLE_W-1:0], exp_s);
         end
         exp_s = exp_s + `SAMPLE_W'(1);
      end
      read_reg(reg_buf_data, rd);
      check_word("buf_data past the count", rd, '0);
      // top bit set means rising past the level
      passable = r.level[`SAMPLE_W-1] ? (r.level != '1) : (r.level != '0);
      check_word("level pulses", `WB_DW'(pulse_total - pulses_before), passable ? 32'd1 : 32'd0);
      if (passable && r.src == src_adc) begin
         past = r.level[`SAMPLE_W-1] ? (pulse_sample > r.level) : (pulse_sample < r.level);
         check_word("level crossing", `WB_DW'(past), 32'd1);
      end
   endtask

   initial begin
      logic [`WB_DW-1:0] rd;
      int                k;
      void'($urandom(32'hcc70_ba97));
      reset     = 1'b1;
      wb_cyc_i  = 1'b0;
      wb_stb_i  = 1'b0;
      wb_we_i   = 1'b0;
      wb_adr_i  = '0;
      wb_dat_i  = '0;
      trigger_i = 1'b0;
      fill_table();
      repeat (5) @(posedge ADC_clk_sample);
      @(negedge ADC_clk_sample);
      reset <= 1'b0;
      @(negedge ADC_clk_sample);
      expect_state("fsm state after reset", dut_i.u_fsm.state_q, st_idle);
      read_reg(reg_status, rd);
      check_word("status after reset", rd, '0);
      write_reg(reg_sample_count, 32'd1000);   // above the buffer depth
      read_reg(reg_sample_count, rd);
      check_word("saturated sample_count", rd, 32'd512);
      for (k = 0; k < NROWS; k++)
         run_row(k, rows[k]);
      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule
